// ==== verilog/isa_pkg.sv ====
/* ISA package for the execution cluster
   Instruction word layout, major opcodes and function codes */
package isa_pkg;

	// ============================================================
	// Major opcodes
	// ============================================================

	// Encodings above OP_FSGN are not assigned
	// The execution unit answers them with an illegal-instruction cause
	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUBF  = 4'd2,
		OP_AND   = 4'd3,
		OP_OR    = 4'd4,
		OP_XOR   = 4'd5,
		OP_CMP   = 4'd6,
		OP_MOV   = 4'd7,
		OP_LOADA = 4'd8,
		OP_MUL   = 4'd9,
		OP_FSGN  = 4'd10
	} opcode_t;

	// Decoded instruction as handed to the execution unit
	// Scale is only looked at by LOADA as the shift applied to b
	typedef struct packed {
		opcode_t    opcode;
		logic [2:0] func;
		logic       use_imm;
		logic [1:0] scale;
	} instr_t;

	// ============================================================
	// Function codes
	// ============================================================

	// Logic group, shared by AND, OR and XOR
	localparam logic [2:0] FN_PLAIN = 3'd0;
	localparam logic [2:0] FN_INV   = 3'd1;
	localparam logic [2:0] FN_ANDN  = 3'd2;

	// Add group
	localparam logic [2:0] FN_SUM   = 3'd0;
	localparam logic [2:0] FN_ABS   = 3'd2;

	// Move group
	// The select forms test a against zero and pick b or c
	localparam logic [2:0] FN_COPY   = 3'd0;
	localparam logic [2:0] FN_SEL_Z  = 3'd4;
	localparam logic [2:0] FN_SEL_NZ = 3'd5;

	// Sign inject group working on the IEEE sign bit
	localparam logic [2:0] FN_SGNJ  = 3'd0;
	localparam logic [2:0] FN_SGNJN = 3'd1;
	localparam logic [2:0] FN_SGNJX = 3'd2;

endpackage

// ==== verilog/exec_pkg.sv ====
/* Execution cluster package
   Data widths, packet and result records, cause codes and multiplier latency */
package exec_pkg;

	// ============================================================
	// Widths and latency
	// ============================================================

	localparam int DATA_W = 64;
	localparam int TAG_W  = 4;

	// The multiplier retires one multiplier bit per cycle
	localparam int MUL_CYCLES = 64;
	localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

	// Result cause reported alongside every value
	typedef enum logic [1:0] {
		CAUSE_NONE    = 2'd0,
		CAUSE_ILLEGAL = 2'd1
	} cause_t;

	// ============================================================
	// Channel payloads
	// ============================================================

	// Operation packet carried from the input port to the unit
	// 10 bits of instruction, four data words and the tag
	typedef struct packed {
		isa_pkg::instr_t   instr;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] c;
		logic [DATA_W-1:0] imm;
		logic [TAG_W-1:0]  tag;
	} op_pkt_t;

	// Result record leaving the unit, 70 bits wide
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] value;
		cause_t            cause;
	} result_t;

endpackage

// ==== verilog/hs_slot.sv ====
/* One-entry four-phase register slot
   Accepts an item as handshake slave and offers it on as handshake master */
`timescale 1ns/1ns

module hs_slot #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     up_req,
	output logic     up_ack,
	input  payload_t up_data,
	output logic     dn_req,
	input  logic     dn_ack,
	output payload_t dn_data
);

	// Empty, holding a fresh item, offering it, and waiting for ack to fall
	typedef enum logic [1:0] {
		SL_EMPTY,
		SL_HELD,
		SL_OFFER,
		SL_DRAIN
	} slot_state_t;

	slot_state_t state;
	payload_t    data_q;
	logic        take;

	// A new item is taken only when empty and the last upstream cycle has closed
	assign take = (state == SL_EMPTY) && up_req && !up_ack;

	// ============================================================
	// Handshake control
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state  <= SL_EMPTY;
			up_ack <= 1'b0;
			dn_req <= 1'b0;
		end
		else
		begin
			// Upstream ack is released once the sender has dropped req
			if (up_ack && !up_req)
				up_ack <= 1'b0;
			case (state)
			SL_EMPTY:
				if (take)
				begin
					up_ack <= 1'b1;
					state  <= SL_HELD;
				end
			SL_HELD:
				begin
					// Offer goes out the cycle after the capture
					dn_req <= 1'b1;
					state  <= SL_OFFER;
				end
			SL_OFFER:
				if (dn_ack)
				begin
					dn_req <= 1'b0;
					state  <= SL_DRAIN;
				end
			SL_DRAIN:
				// The slot frees up only when the receiver has closed its side
				if (!dn_ack)
					state <= SL_EMPTY;
			default:
				state <= SL_EMPTY;
			endcase
		end
	end

	// Item storage
	always_ff @(posedge clk)
	begin
		if (take)
			data_q <= up_data;
	end

	assign dn_data = data_q;

	// An acknowledge must always answer a request seen one cycle earlier
	assert property (@(posedge clk) disable iff (rst) $rose(up_ack) |-> $past(up_req));

	// An offer is never withdrawn before the receiver has answered it
	assert property (@(posedge clk) disable iff (rst) dn_req && !dn_ack |=> dn_req);

endmodule

// ==== verilog/mul_shift_add.sv ====
/* Iterative shift-add multiplier
   Produces the low DATA_W bits of a times b after MUL_CYCLES steps */
`timescale 1ns/1ns

module mul_shift_add (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        start,
	input  logic [exec_pkg::DATA_W-1:0] a,
	input  logic [exec_pkg::DATA_W-1:0] b,
	output logic [exec_pkg::DATA_W-1:0] product,
	output logic                        done
);
	import exec_pkg::*;

	logic [DATA_W-1:0]    mcand;
	logic [DATA_W-1:0]    mplier;
	logic [DATA_W-1:0]    acc;
	logic [MUL_CNT_W-1:0] step;
	logic                 busy;
	logic                 last_step;

	assign last_step = (step == MUL_CNT_W'(MUL_CYCLES - 1));

	// ============================================================
	// Step counter and done pulse
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			step <= '0;
			done <= 1'b0;
		end
		else
		begin
			// Done is a single-cycle pulse
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				step <= '0;
			end
			else if (busy)
			begin
				step <= step + 1'b1;
				if (last_step)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// ============================================================
	// Shift-add datapath
	// ============================================================

	// The multiplicand walks left while the multiplier walks right
	// Bits shifted past the top are dropped so acc keeps the low half
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			mcand  <= a;
			mplier <= b;
			acc    <= '0;
		end
		else if (busy)
		begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// Accumulator holds its value after done until the next start
	assign product = acc;

	// The issuing unit must wait for done before launching another multiply
	assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// ==== verilog/exec_unit.sv ====
/* Integer and float-sign execution unit
   Decodes one operation, forms its result and offers it over a four-phase channel */
`timescale 1ns/1ns

module exec_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              op_req,
	output logic              op_ack,
	input  exec_pkg::op_pkt_t op,
	output logic              res_req,
	input  logic              res_ack,
	output exec_pkg::result_t res
);
	import isa_pkg::*;
	import exec_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL_WAIT,
		ST_OFFER
	} unit_state_t;

	unit_state_t       state;
	op_pkt_t           pkt;
	logic              accept;
	logic              mul_start;
	logic [DATA_W-1:0] mul_b;
	logic [DATA_W-1:0] mul_product;
	logic              mul_done;
	logic [DATA_W-1:0] op2;
	logic [DATA_W-1:0] sum;
	logic [DATA_W-1:0] value;
	logic              illegal;

	// Logic group helper, the opcode picks the gate
	function automatic logic [DATA_W-1:0] logic_fn(
		input opcode_t           opc,
		input logic [DATA_W-1:0] x,
		input logic [DATA_W-1:0] y
	);
		case (opc)
		OP_AND:  logic_fn = x & y;
		OP_OR:   logic_fn = x | y;
		default: logic_fn = x ^ y;
		endcase
	endfunction

	// ============================================================
	// Issue and handshake control
	// ============================================================

	// A new operation is taken only once the previous result cycle is fully closed
	assign accept = (state == ST_IDLE) && op_req && !op_ack && !res_ack;

	// The multiply is launched straight from the incoming packet
	// so that it finishes MUL_CYCLES after the normal result time
	assign mul_start = accept && (op.instr.opcode == OP_MUL);
	assign mul_b     = op.instr.use_imm ? op.imm : op.b;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= ST_IDLE;
			op_ack  <= 1'b0;
			res_req <= 1'b0;
		end
		else
		begin
			// Input side ack falls as soon as the sender lets go
			if (op_ack && !op_req)
				op_ack <= 1'b0;
			case (state)
			ST_IDLE:
				if (accept)
				begin
					op_ack <= 1'b1;
					state  <= (op.instr.opcode == OP_MUL) ? ST_MUL_WAIT : ST_OFFER;
				end
			ST_MUL_WAIT:
				if (mul_done)
				begin
					res_req <= 1'b1;
					state   <= ST_OFFER;
				end
			ST_OFFER:
				// Single-cycle ops raise req here, one cycle after the capture
				if (!res_req)
					res_req <= 1'b1;
				else if (res_ack)
				begin
					res_req <= 1'b0;
					state   <= ST_IDLE;
				end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// Packet register
	always_ff @(posedge clk)
	begin
		if (accept)
			pkt <= op;
	end

	mul_shift_add u_mul (
		.clk    (clk),
		.rst    (rst),
		.start  (mul_start),
		.a      (op.a),
		.b      (mul_b),
		.product(mul_product),
		.done   (mul_done)
	);

	// ============================================================
	// Result selector
	// ============================================================

	// Second operand comes from the immediate when use_imm is set
	assign op2 = pkt.instr.use_imm ? pkt.imm : pkt.b;
	assign sum = pkt.a + op2;

	always_comb
	begin
		value   = '0;
		illegal = 1'b0;
		case (pkt.instr.opcode)
		OP_NOP:
			value = pkt.c;
		OP_ADD:
			case (pkt.instr.func)
			FN_SUM:  value = sum;
			FN_ABS:  value = sum[DATA_W-1] ? -sum : sum;
			default: illegal = 1'b1;
			endcase
		OP_SUBF:
			// Reverse subtract
			value = op2 - pkt.a;
		OP_AND,
		OP_OR,
		OP_XOR:
			case (pkt.instr.func)
			FN_PLAIN: value = logic_fn(pkt.instr.opcode, pkt.a, op2);
			FN_INV:   value = ~logic_fn(pkt.instr.opcode, pkt.a, op2);
			FN_ANDN:  value = logic_fn(pkt.instr.opcode, pkt.a, ~op2);
			default:  illegal = 1'b1;
			endcase
		OP_CMP:
			begin
				// Flag word with equal, signed less and unsigned less
				value[0] = (pkt.a == op2);
				value[1] = ($signed(pkt.a) < $signed(op2));
				value[2] = (pkt.a < op2);
			end
		OP_MOV:
			case (pkt.instr.func)
			FN_COPY:   value = pkt.a;
			FN_SEL_Z:  value = (pkt.a == '0) ? pkt.b : pkt.c;
			FN_SEL_NZ: value = (pkt.a != '0) ? pkt.b : pkt.c;
			default:   illegal = 1'b1;
			endcase
		OP_LOADA:
			value = pkt.a + pkt.imm + (pkt.b << pkt.instr.scale);
		OP_FSGN:
			// Magnitude always comes from b
			case (pkt.instr.func)
			FN_SGNJ:  value = {pkt.a[DATA_W-1], pkt.b[DATA_W-2:0]};
			FN_SGNJN: value = {~pkt.a[DATA_W-1], pkt.b[DATA_W-2:0]};
			FN_SGNJX: value = {pkt.a[DATA_W-1] ^ pkt.b[DATA_W-1], pkt.b[DATA_W-2:0]};
			default:  illegal = 1'b1;
			endcase
		OP_MUL:
			value = mul_product;
		default:
			illegal = 1'b1;
		endcase
	end

	// Tag rides along unchanged
	assign res.tag   = pkt.tag;
	assign res.value = value;
	assign res.cause = illegal ? CAUSE_ILLEGAL : CAUSE_NONE;

	// The offered result must hold until the output slot has answered
	assert property (@(posedge clk) disable iff (rst) res_req && !res_ack |=> $stable(res));

endmodule

// ==== verilog/exec_cluster.sv ====
/* Execution cluster top level
   Input slot, execution unit and output slot chained by four-phase channels */
`timescale 1ns/1ns

module exec_cluster (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_req,
	output logic                        in_ack,
	input  isa_pkg::instr_t             in_instr,
	input  logic [exec_pkg::DATA_W-1:0] in_a,
	input  logic [exec_pkg::DATA_W-1:0] in_b,
	input  logic [exec_pkg::DATA_W-1:0] in_c,
	input  logic [exec_pkg::DATA_W-1:0] in_imm,
	input  logic [exec_pkg::TAG_W-1:0]  in_tag,
	output logic                        out_req,
	input  logic                        out_ack,
	output logic [exec_pkg::DATA_W-1:0] out_value,
	output logic [exec_pkg::TAG_W-1:0]  out_tag,
	output exec_pkg::cause_t            out_cause
);
	import exec_pkg::*;

	op_pkt_t in_pkt;
	op_pkt_t op;
	logic    op_req;
	logic    op_ack;
	result_t res;
	logic    res_req;
	logic    res_ack;
	result_t out_res;

	// Gather the loose input fields into one packet
	assign in_pkt.instr = in_instr;
	assign in_pkt.a     = in_a;
	assign in_pkt.b     = in_b;
	assign in_pkt.c     = in_c;
	assign in_pkt.imm   = in_imm;
	assign in_pkt.tag   = in_tag;

	// Channel 1 into channel 2
	hs_slot #(.payload_t(op_pkt_t)) in_slot (
		.clk    (clk),
		.rst    (rst),
		.up_req (in_req),
		.up_ack (in_ack),
		.up_data(in_pkt),
		.dn_req (op_req),
		.dn_ack (op_ack),
		.dn_data(op)
	);

	exec_unit u_exec (
		.clk    (clk),
		.rst    (rst),
		.op_req (op_req),
		.op_ack (op_ack),
		.op     (op),
		.res_req(res_req),
		.res_ack(res_ack),
		.res    (res)
	);

	// Channel 3 out to the external result port
	hs_slot #(.payload_t(result_t)) out_slot (
		.clk    (clk),
		.rst    (rst),
		.up_req (res_req),
		.up_ack (res_ack),
		.up_data(res),
		.dn_req (out_req),
		.dn_ack (out_ack),
		.dn_data(out_res)
	);

	// Split the result record back onto the output pins
	assign out_value = out_res.value;
	assign out_tag   = out_res.tag;
	assign out_cause = out_res.cause;

endmodule

// ==== sim/exec_cluster_tb.sv ====
/* Execution cluster testbench
   Directed tests over both four-phase ports with results checked against a reference model */
`timescale 1ns/1ns

module exec_cluster_tb;
	import isa_pkg::*;
	import exec_pkg::*;

	// Bound for one handshake step since a multiply alone needs about 70 cycles
	localparam int WAIT_LIMIT  = 300;
	// How long the input side is watched for an acknowledge under back-pressure
	localparam int STALL_LIMIT = 150;

	logic              clk;
	logic              rst;
	logic              in_req;
	logic              in_ack;
	instr_t            in_instr;
	logic [DATA_W-1:0] in_a;
	logic [DATA_W-1:0] in_b;
	logic [DATA_W-1:0] in_c;
	logic [DATA_W-1:0] in_imm;
	logic [TAG_W-1:0]  in_tag;
	logic              out_req;
	logic              out_ack;
	logic [DATA_W-1:0] out_value;
	logic [TAG_W-1:0]  out_tag;
	cause_t            out_cause;

	int                seed;
	logic [TAG_W-1:0]  next_tag;

	// Expected results in sending order
	logic [DATA_W-1:0] exp_value_q[$];
	cause_t            exp_cause_q[$];
	logic [TAG_W-1:0]  exp_tag_q[$];

	exec_cluster UUT (
		.clk      (clk),
		.rst      (rst),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.in_instr (in_instr),
		.in_a     (in_a),
		.in_b     (in_b),
		.in_c     (in_c),
		.in_imm   (in_imm),
		.in_tag   (in_tag),
		.out_req  (out_req),
		.out_ack  (out_ack),
		.out_value(out_value),
		.out_tag  (out_tag),
		.out_cause(out_cause)
	);

	always #10 clk = ~clk;

	// ============================================================
	// Reference model and helpers
	// ============================================================

	// Expected value and cause derived from the opcode rules
	function automatic void model_op(input instr_t ins, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] c,
		input logic [DATA_W-1:0] imm, output logic [DATA_W-1:0] val, output cause_t cause);
		logic [DATA_W-1:0] y;
		logic [DATA_W-1:0] s;
		logic [DATA_W-1:0] y_eff;
		logic [DATA_W-1:0] g;
		y = ins.use_imm ? imm : b;
		s = a + y;
		val = '0;
		cause = CAUSE_NONE;
		case (ins.opcode)
		OP_NOP:   val = c;
		OP_ADD:
			if (ins.func == FN_SUM)
				val = s;
			else if (ins.func == FN_ABS)
				val = s[DATA_W-1] ? (~s + 64'd1) : s;
			else
				cause = CAUSE_ILLEGAL;
		OP_SUBF:  val = y - a;
		OP_AND,
		OP_OR,
		OP_XOR:
			begin
				// ANDN forms apply the gate to the inverted second operand
				y_eff = (ins.func == FN_ANDN) ? ~y : y;
				if (ins.opcode == OP_AND)
					g = a & y_eff;
				else if (ins.opcode == OP_OR)
					g = a | y_eff;
				else
					g = a ^ y_eff;
				if (ins.func == FN_PLAIN || ins.func == FN_ANDN)
					val = g;
				else if (ins.func == FN_INV)
					val = ~g;
				else
					cause = CAUSE_ILLEGAL;
			end
		OP_CMP:   val = {61'd0, a < y, $signed(a) < $signed(y), a == y};
		OP_MOV:
			if (ins.func == FN_COPY)
				val = a;
			else if (ins.func == FN_SEL_Z)
				val = (a == 64'd0) ? b : c;
			else if (ins.func == FN_SEL_NZ)
				val = (a != 64'd0) ? b : c;
			else
				cause = CAUSE_ILLEGAL;
		OP_LOADA: val = a + imm + (b << ins.scale);
		OP_MUL:   val = a * y;
		OP_FSGN:
			if (ins.func == FN_SGNJ)
				val = {a[DATA_W-1], b[DATA_W-2:0]};
			else if (ins.func == FN_SGNJN)
				val = {~a[DATA_W-1], b[DATA_W-2:0]};
			else if (ins.func == FN_SGNJX)
				val = {a[DATA_W-1] ^ b[DATA_W-1], b[DATA_W-2:0]};
			else
				cause = CAUSE_ILLEGAL;
		default:  cause = CAUSE_ILLEGAL;
		endcase
		if (cause == CAUSE_ILLEGAL)
			val = '0;
	endfunction

	function automatic instr_t make_instr(input opcode_t opc, input logic [2:0] fn,
		input logic use_imm, input logic [1:0] scale);
		instr_t ins;
		ins.opcode  = opc;
		ins.func    = fn;
		ins.use_imm = use_imm;
		ins.scale   = scale;
		return ins;
	endfunction

	function automatic logic [DATA_W-1:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Inputs change 2 ns after the edge and outputs are read at the same point
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_in_ack(input logic level, input int limit, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < limit && !ok; n++)
		begin
			next_cycle();
			if (in_ack == level)
				ok = 1'b1;
		end
	endtask

	task automatic wait_out_req(input logic level, input int limit, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < limit && !ok; n++)
		begin
			next_cycle();
			if (out_req == level)
				ok = 1'b1;
		end
	endtask

	// ============================================================
	// Handshake tasks
	// ============================================================

	// Presents an operation and records what should come back for it
	task automatic start_op(input instr_t ins, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] c, input logic [DATA_W-1:0] imm);
		logic [DATA_W-1:0] v;
		cause_t            cs;
		model_op(ins, a, b, c, imm, v, cs);
		exp_value_q.push_back(v);
		exp_cause_q.push_back(cs);
		exp_tag_q.push_back(next_tag);
		next_cycle();
		in_instr = ins;
		in_a     = a;
		in_b     = b;
		in_c     = c;
		in_imm   = imm;
		in_tag   = next_tag;
		in_req   = 1'b1;
		next_tag = next_tag + 4'd1;
	endtask

	task automatic release_op();
		bit ok;
		in_req = 1'b0;
		wait_in_ack(1'b0, WAIT_LIMIT, ok);
		assert (ok) else abort_run("in_ack did not fall after in_req was dropped");
	endtask

	task automatic finish_op();
		bit ok;
		wait_in_ack(1'b1, WAIT_LIMIT, ok);
		assert (ok) else abort_run("in_ack did not rise for a pending operation");
		release_op();
	endtask

	// Takes one result and compares it with the oldest expected entry
	task automatic recv_result();
		bit ok;
		assert (exp_tag_q.size() > 0) else abort_run("Result wait with nothing outstanding");
		wait_out_req(1'b1, WAIT_LIMIT, ok);
		assert (ok) else abort_run("out_req did not rise for an outstanding operation");
		check_value("out_tag", 64'(out_tag), 64'(exp_tag_q.pop_front()));
		check_value("out_value", out_value, exp_value_q.pop_front());
		check_value("out_cause", 64'(out_cause), 64'(exp_cause_q.pop_front()));
		out_ack = 1'b1;
		wait_out_req(1'b0, WAIT_LIMIT, ok);
		assert (ok) else abort_run("out_req did not fall after out_ack was raised");
		out_ack = 1'b0;
	endtask

	task automatic run_op(input instr_t ins, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] c, input logic [DATA_W-1:0] imm);
		start_op(ins, a, b, c, imm);
		finish_op();
		recv_result();
	endtask

	// ============================================================
	// Directed tests
	// ============================================================

	task automatic test_alu_ops();
		opcode_t    logic_ops[3];
		logic [2:0] logic_fns[3];
		int         m;
		int         i;
		int         j;
		logic_ops = '{OP_AND, OP_OR, OP_XOR};
		logic_fns = '{FN_PLAIN, FN_INV, FN_ANDN};
		// Register form first and the immediate form second
		for (m = 0; m < 2; m++)
		begin
			run_op(make_instr(OP_ADD, FN_SUM, m[0], 2'd0), rand64(), rand64(), 64'd0, rand64());
			run_op(make_instr(OP_ADD, FN_ABS, m[0], 2'd0), rand64(), rand64(), 64'd0, rand64());
			// Negative sum so that the absolute value has to flip it
			run_op(make_instr(OP_ADD, FN_ABS, m[0], 2'd0), -64'd100, 64'd7, 64'd0, 64'd9);
			run_op(make_instr(OP_SUBF, 3'd0, m[0], 2'd0), rand64(), rand64(), 64'd0, rand64());
			for (i = 0; i < 3; i++)
				for (j = 0; j < 3; j++)
					run_op(make_instr(logic_ops[i], logic_fns[j], m[0], 2'd0),
						rand64(), rand64(), 64'd0, rand64());
		end
	endtask

	task automatic test_misc_ops();
		logic [DATA_W-1:0] sgn_a[2];
		logic [DATA_W-1:0] sgn_b[2];
		logic [2:0]        sgn_fns[3];
		int                i;
		int                j;
		int                k;
		sgn_a   = '{64'h8000_0000_0000_0001, 64'h3ff0_0000_0000_0000};
		sgn_b   = '{64'hbff8_0000_0000_0000, 64'h7fff_ffff_ffff_ffff};
		sgn_fns = '{FN_SGNJ, FN_SGNJN, FN_SGNJX};
		// Equal, signed and unsigned orderings disagreeing on purpose
		run_op(make_instr(OP_CMP, 3'd0, 1'b0, 2'd0), 64'd5, 64'd5, 64'd0, 64'd0);
		run_op(make_instr(OP_CMP, 3'd0, 1'b0, 2'd0), -64'd1, 64'd1, 64'd0, 64'd0);
		run_op(make_instr(OP_CMP, 3'd0, 1'b0, 2'd0), 64'd1, -64'd1, 64'd0, 64'd0);
		run_op(make_instr(OP_CMP, 3'd0, 1'b1, 2'd0), 64'd0, 64'd3, 64'd0,
			64'h8000_0000_0000_0000);
		run_op(make_instr(OP_MOV, FN_COPY, 1'b0, 2'd0), rand64(), rand64(), rand64(), 64'd0);
		run_op(make_instr(OP_MOV, FN_SEL_Z, 1'b0, 2'd0), 64'd0, rand64(), rand64(), 64'd0);
		run_op(make_instr(OP_MOV, FN_SEL_Z, 1'b0, 2'd0), 64'd3, rand64(), rand64(), 64'd0);
		run_op(make_instr(OP_MOV, FN_SEL_NZ, 1'b0, 2'd0), 64'd0, rand64(), rand64(), 64'd0);
		run_op(make_instr(OP_MOV, FN_SEL_NZ, 1'b0, 2'd0), 64'd3, rand64(), rand64(), 64'd0);
		run_op(make_instr(OP_NOP, 3'd0, 1'b0, 2'd0), rand64(), rand64(), rand64(), rand64());
		for (i = 0; i < 4; i++)
			run_op(make_instr(OP_LOADA, 3'd0, 1'b0, i[1:0]), 64'h1000, rand64(), 64'd0, 64'h8);
		for (i = 0; i < 2; i++)
			for (j = 0; j < 2; j++)
				for (k = 0; k < 3; k++)
					run_op(make_instr(OP_FSGN, sgn_fns[k], 1'b0, 2'd0), sgn_a[i], sgn_b[j],
						64'd0, 64'd0);
	endtask

	task automatic test_multiply();
		int i;
		for (i = 0; i < 20; i++)
			run_op(make_instr(OP_MUL, 3'd0, i[0], 2'd0), rand64(), rand64(), 64'd0, rand64());
	endtask

	task automatic test_illegal();
		run_op(make_instr(opcode_t'(4'd13), 3'd0, 1'b0, 2'd0), rand64(), rand64(), rand64(),
			64'd0);
		run_op(make_instr(OP_ADD, 3'd5, 1'b0, 2'd0), rand64(), rand64(), rand64(), 64'd0);
	endtask

	// Five operations with out_ack held low followed by an in-order drain
	task automatic test_backpressure();
		instr_t ins[5];
		int     sent;
		int     accepted;
		int     r;
		bit     ok;
		bit     stalled;
		ins = '{make_instr(OP_ADD, FN_SUM, 1'b0, 2'd0), make_instr(OP_XOR, FN_INV, 1'b0, 2'd0),
			make_instr(OP_MUL, 3'd0, 1'b0, 2'd0), make_instr(OP_SUBF, 3'd0, 1'b1, 2'd0),
			make_instr(OP_LOADA, 3'd0, 1'b0, 2'd3)};
		sent    = 0;
		stalled = 1'b0;
		while (sent < 5 && !stalled)
		begin
			start_op(ins[sent], rand64(), rand64(), rand64(), rand64());
			wait_in_ack(1'b1, STALL_LIMIT, ok);
			if (ok)
				release_op();
			else
				stalled = 1'b1;
			sent++;
		end
		accepted = stalled ? sent - 1 : sent;
		assert (stalled && accepted <= 3)
		else
			abort_run($sformatf("in_ack kept answering under back-pressure, %0d accepted",
				accepted));
		// Each drained result frees room for the held or the next operation
		for (r = 0; r < 5; r++)
		begin
			recv_result();
			if (stalled)
			begin
				finish_op();
				stalled = 1'b0;
			end
			else if (sent < 5)
			begin
				start_op(ins[sent], rand64(), rand64(), rand64(), rand64());
				finish_op();
				sent++;
			end
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial
	begin
		int i;
		seed     = 59098;
		next_tag = '0;
		clk      = 1'b0;
		rst      = 1'b1;
		in_req   = 1'b0;
		in_instr = '0;
		in_a     = '0;
		in_b     = '0;
		in_c     = '0;
		in_imm   = '0;
		in_tag   = '0;
		out_ack  = 1'b0;
		// A request held during reset must go unanswered and nothing may leave the output
		// The request is withdrawn before reset ends so the cluster starts out empty
		for (i = 0; i < 10; i++)
		begin
			next_cycle();
			if (i == 0)
				in_req = 1'b1;
			if (i == 6)
				in_req = 1'b0;
			if (i == 7)
				rst = 1'b0;
			assert (!in_ack && !out_req)
			else
				abort_run($sformatf("FAILED in_ack/out_req: got 0x%h/0x%h expected 0x0/0x0",
					in_ack, out_req));
		end
		test_alu_ops();
		test_misc_ops();
		test_multiply();
		test_illegal();
		test_backpressure();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== list.f ====
verilog/isa_pkg.sv
verilog/exec_pkg.sv
verilog/hs_slot.sv
verilog/mul_shift_add.sv
verilog/exec_unit.sv
verilog/exec_cluster.sv
sim/exec_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the execution cluster testbench with Verilator and runs it
# The exit status is nonzero when the build fails or the testbench stops with $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module exec_cluster_tb -o exec_cluster_sim &&
./obj_dir/exec_cluster_sim ||
{ echo "Build or run ended with an error"; exit 1; }
